// File: r2_pkg.sv
package r2_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        IDLE       = 3'b000,
        START      = 3'b001,
        START_ROW  = 3'b010,
        SUM_EN     = 3'b011,
        CUM_EN     = 3'b100,
        FINISH_ALL = 3'b101
    } r2_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counter widths and phase thresholds
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Window counter and phase counter width.
    localparam int CNT_W = 10;

    // Start counter value that ends the start phase.
    localparam logic [1:0] START_LAST = 2'd2;

    // Phase count on the last summing cycle.
    localparam logic [CNT_W-1:0] SUM_LAST = 10'd4;

    // Phase count on the last cumulative cycle.
    localparam logic [CNT_W-1:0] CUM_LAST = 10'd6;

endpackage

// File: r2_ctrl_if.sv
`timescale 1ns/1ns

interface r2_ctrl_if;

    logic start_en;  // High through the start phase.
    logic ld_en;     // Row load, clears the phase counter and row sum.
    logic count_en;  // Phase counter enable.
    logic sum_en;    // Adds the sample into the row sum.
    logic cum_en;    // Cumulative phase of a row.
    logic row_done;  // Row sum is complete.

    modport ctrl (
        output start_en, ld_en, count_en, sum_en, cum_en, row_done
    );

    modport exec (
        input start_en, ld_en, count_en, sum_en
    );

    modport res (
        input start_en, cum_en, row_done
    );

endinterface

// File: r2_controller.sv
`timescale 1ns/1ns

module r2_controller #(
    parameter int COLS = 40
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     done_i,
    input  logic                     start_gt_1,
    input  logic [r2_pkg::CNT_W-1:0] phase_count,
    r2_ctrl_if.ctrl                  ctl,
    output logic                     progress_done,
    output logic                     done_delayed
);

    localparam logic [r2_pkg::CNT_W-1:0] WIN_LAST = COLS[r2_pkg::CNT_W-1:0];

    logic [r2_pkg::CNT_W-1:0] win_cnt;
    logic                     win_ext;

    r2_pkg::r2_state_e state;
    r2_pkg::r2_state_e state_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Done stretcher
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_cnt <= '0;
            win_ext <= 1'b0;
        end else if (done_i) begin
            win_cnt <= '0;      // A new pulse restarts the stretch.
            win_ext <= 1'b1;
        end else if (win_ext && win_cnt < WIN_LAST) begin
            win_cnt <= win_cnt + 1'b1;
            win_ext <= 1'b1;
        end else begin
            win_cnt <= '0;
            win_ext <= 1'b0;
        end
    end

    assign done_delayed = done_i | win_ext;  // COLS plus 2 cycles in all.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= r2_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            r2_pkg::IDLE: begin
                if (done_delayed) begin
                    state_nxt = r2_pkg::START;
                end
            end
            r2_pkg::START: begin
                if (start_gt_1) begin
                    state_nxt = r2_pkg::START_ROW;
                end
            end
            r2_pkg::START_ROW: begin
                state_nxt = r2_pkg::SUM_EN;
            end
            r2_pkg::SUM_EN: begin
                if (phase_count >= r2_pkg::SUM_LAST) begin
                    state_nxt = r2_pkg::CUM_EN;
                end
            end
            r2_pkg::CUM_EN: begin
                if (phase_count >= r2_pkg::CUM_LAST) begin
                    state_nxt = r2_pkg::START_ROW;
                end
            end
            default: begin
                state_nxt = r2_pkg::IDLE;  // FINISH_ALL and unused codes.
            end
        endcase
        // The window closing ends the burst from any active state.
        if (state != r2_pkg::IDLE && state != r2_pkg::FINISH_ALL && !done_delayed) begin
            state_nxt = r2_pkg::FINISH_ALL;
        end
    end

    // Moore outputs, all low unless the state sets them.
    always_comb begin
        ctl.start_en  = 1'b0;
        ctl.ld_en     = 1'b0;
        ctl.count_en  = 1'b0;
        ctl.sum_en    = 1'b0;
        ctl.cum_en    = 1'b0;
        ctl.row_done  = 1'b0;
        progress_done = 1'b0;
        case (state)
            r2_pkg::START: begin
                ctl.start_en = 1'b1;
            end
            r2_pkg::START_ROW: begin
                ctl.ld_en    = 1'b1;
                ctl.count_en = 1'b1;
            end
            r2_pkg::SUM_EN: begin
                ctl.count_en = 1'b1;
                ctl.sum_en   = 1'b1;
            end
            r2_pkg::CUM_EN: begin
                ctl.count_en = 1'b1;
                ctl.cum_en   = 1'b1;
                ctl.row_done = 1'b1;
            end
            r2_pkg::FINISH_ALL: begin
                progress_done = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: r2_execute.sv
`timescale 1ns/1ns

module r2_execute #(
    parameter int DATA_W = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [DATA_W-1:0]        sample_in,
    r2_ctrl_if.exec                  ctl,
    output logic                     start_gt_1,
    output logic [r2_pkg::CNT_W-1:0] phase_count,
    output logic [DATA_W+2:0]        row_acc
);

    localparam int ACC_W   = DATA_W + 3;  // Five samples fit in three extra bits.
    localparam int START_W = $bits(r2_pkg::START_LAST);

    logic [START_W-1:0] start_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Start counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_cnt <= '0;
        end else if (!ctl.start_en) begin
            start_cnt <= '0;
        end else if (!start_gt_1) begin
            start_cnt <= start_cnt + 1'b1;  // Holds once the last count is reached.
        end
    end

    assign start_gt_1 = (start_cnt >= r2_pkg::START_LAST);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The load strobe wins over the count enable in START_ROW.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_count <= '0;
        end else if (ctl.ld_en) begin
            phase_count <= '0;
        end else if (ctl.count_en) begin
            phase_count <= phase_count + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Row accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_acc <= '0;
        end else if (ctl.ld_en) begin
            row_acc <= '0;
        end else if (ctl.sum_en) begin
            row_acc <= row_acc + ACC_W'(sample_in);  // Samples are unsigned.
        end
    end

endmodule

// File: r2_result.sv
`timescale 1ns/1ns

module r2_result #(
    parameter int DATA_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    r2_ctrl_if.res             ctl,
    input  logic [DATA_W+2:0]  row_acc,
    input  logic               progress_done,
    output logic               row_valid,
    output logic [DATA_W+2:0]  row_sum,
    output logic               total_valid,
    output logic [DATA_W+15:0] total_sum,
    output logic [7:0]         row_count
);

    localparam int TOT_W = DATA_W + 16;

    logic cum_seen;
    logic row_first;

    // CUM_EN lasts two cycles and the row is taken on the first only.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cum_seen <= 1'b0;
        end else begin
            cum_seen <= ctl.cum_en;
        end
    end

    assign row_first = ctl.row_done & ~cum_seen;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Running total and row count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_valid   <= 1'b0;
            total_valid <= 1'b0;
            total_sum   <= '0;
            row_count   <= '0;
        end else begin
            row_valid   <= row_first;
            total_valid <= progress_done;   // Total is final one cycle after FINISH_ALL.
            if (ctl.start_en) begin
                total_sum <= '0;            // A new burst starts from zero.
                row_count <= '0;
            end else if (row_first) begin
                total_sum <= total_sum + TOT_W'(row_acc);
                row_count <= row_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_first) begin
            row_sum <= row_acc;
        end
    end

endmodule

// File: r2_top.sv
`timescale 1ns/1ns

module r2_top #(
    parameter int COLS   = 40,
    parameter int DATA_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               done_i,
    input  logic [DATA_W-1:0]  sample_in,
    output logic               done_delayed,
    output logic               row_valid,
    output logic [DATA_W+2:0]  row_sum,
    output logic               total_valid,
    output logic [DATA_W+15:0] total_sum,
    output logic [7:0]         row_count
);

    logic                     start_gt_1;
    logic [r2_pkg::CNT_W-1:0] phase_count;
    logic [DATA_W+2:0]        row_acc;
    logic                     progress_done;

    r2_ctrl_if ctl ();

    r2_controller #(
        .COLS (COLS)
    ) u_controller (
        .clk           (clk),
        .rst           (rst),
        .done_i        (done_i),
        .start_gt_1    (start_gt_1),
        .phase_count   (phase_count),
        .ctl           (ctl.ctrl),
        .progress_done (progress_done),
        .done_delayed  (done_delayed)
    );

    r2_execute #(
        .DATA_W (DATA_W)
    ) u_execute (
        .clk         (clk),
        .rst         (rst),
        .sample_in   (sample_in),
        .ctl         (ctl.exec),
        .start_gt_1  (start_gt_1),
        .phase_count (phase_count),
        .row_acc     (row_acc)
    );

    r2_result #(
        .DATA_W (DATA_W)
    ) u_result (
        .clk           (clk),
        .rst           (rst),
        .ctl           (ctl.res),
        .row_acc       (row_acc),
        .progress_done (progress_done),
        .row_valid     (row_valid),
        .row_sum       (row_sum),
        .total_valid   (total_valid),
        .total_sum     (total_sum),
        .row_count     (row_count)
    );

endmodule

// File: r2_props.sv
`timescale 1ns/1ns

module r2_props #(
    parameter int COLS = 40
) (
    input logic              clk,
    input logic              rst,
    input logic              done_i,
    input logic              done_delayed,
    input logic              progress_done,
    input r2_pkg::r2_state_e state,
    input logic              start_en,
    input logic              ld_en,
    input logic              sum_en,
    input logic              cum_en
);

    int unsigned age_q;             // Cycles since the last done_i pulse.
    logic        pulse_seen;
    logic        in_window;
    int          assert_fails = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            age_q      <= 0;
            pulse_seen <= 1'b0;
        end else if (done_i) begin
            age_q      <= 1;
            pulse_seen <= 1'b1;
        end else if (age_q <= COLS + 2) begin
            age_q <= age_q + 1;     // Saturates once the window is over.
        end
    end

    assign in_window = done_i || (pulse_seen && age_q <= COLS + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({start_en, ld_en, sum_en, cum_en, progress_done}))
        else begin
            assert_fails++;
            $error("More than one controller strobe is high");
        end

    finish_to_idle: assert property (@(posedge clk) disable iff (rst)
        progress_done |=> state == r2_pkg::IDLE)
        else begin
            assert_fails++;
            $error("The state after progress_done is not IDLE");
        end

    window_len: assert property (@(posedge clk) disable iff (rst) done_delayed == in_window)
        else begin
            assert_fails++;
            $error("done_delayed does not span COLS plus 2 cycles from done_i");
        end

endmodule

// File: r2_checker.sv
`timescale 1ns/1ns

module r2_checker #(
    parameter int COLS   = 40,
    parameter int DATA_W = 16
) (
    input logic               clk,
    input logic               rst,
    input logic               done_i,
    input logic               done_delayed,
    input logic               row_valid,
    input logic [DATA_W+2:0]  row_sum,
    input logic               total_valid,
    input logic [DATA_W+15:0] total_sum,
    input logic [7:0]         row_count
);

    localparam int ROW_W = DATA_W + 3;
    localparam int TOT_W = DATA_W + 16;

    logic [ROW_W+TOT_W+7:0] exp_rows [$];    // Row sum, running total and row count.
    logic [TOT_W+7:0]       exp_totals [$];  // Final total and row count of a burst.

    int   value_errors   = 0;
    int   missing_pulses = 0;
    int   extra_pulses   = 0;
    int   other_errors   = 0;
    int   total_seen     = 0;
    int   high_len       = 0;
    logic pulse_seen     = 1'b0;

    function automatic void expect_row(input logic [ROW_W-1:0] sum,
                                       input logic [TOT_W-1:0] total, input logic [7:0] cnt);
        exp_rows.push_back({sum, total, cnt});
    endfunction

    function automatic void expect_total(input logic [TOT_W-1:0] total, input logic [7:0] cnt);
        exp_totals.push_back({total, cnt});
    endfunction

    function automatic int pending_count();
        return exp_rows.size() + exp_totals.size();
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("** Error %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        logic [ROW_W+TOT_W+7:0] row_exp;
        logic [TOT_W+7:0]       tot_exp;
        if (!rst) begin
            if (!pulse_seen && !done_i && (done_delayed || row_valid || total_valid)) begin
                other_errors++;
                $display("Output went high before the first done_i pulse at %0t", $time);
            end
            pulse_seen = pulse_seen | done_i;
            if (done_i && !done_delayed) begin
                other_errors++;
                $display("done_delayed did not rise with done_i at %0t", $time);
            end
            if (done_delayed) begin
                high_len++;
            end else if (high_len != 0) begin
                check_value("done_delayed high cycles", COLS + 2, high_len);
                high_len = 0;
            end
            if (row_valid) begin
                if (exp_rows.size() == 0) begin
                    extra_pulses++;
                    $display("Extra row_valid pulse with no row expected at %0t", $time);
                end else begin
                    row_exp = exp_rows.pop_front();
                    check_value("row_sum", row_exp[ROW_W+TOT_W+7 -: ROW_W], row_sum);
                    check_value("total_sum", row_exp[TOT_W+7:8], total_sum);
                    check_value("row_count", row_exp[7:0], row_count);
                end
            end
            if (total_valid) begin
                total_seen++;
                if (exp_totals.size() == 0) begin
                    extra_pulses++;
                    $display("Extra total_valid pulse with no burst expected at %0t", $time);
                end else begin
                    while (exp_rows.size() != 0) begin
                        missing_pulses++;
                        row_exp = exp_rows.pop_front();
                        $display("A row_valid pulse never came before total_valid at %0t", $time);
                    end
                    tot_exp = exp_totals.pop_front();
                    check_value("total_sum", tot_exp[TOT_W+7:8], total_sum);
                    check_value("row_count", tot_exp[7:0], row_count);
                end
            end
        end
    end

endmodule

// File: tb_r2.sv
`timescale 1ns/1ns

module tb_r2;

    localparam int COLS        = 40;
    localparam int DATA_W      = 16;
    localparam int ROW_W       = DATA_W + 3;
    localparam int TOT_W       = DATA_W + 16;
    localparam int NUM_BURSTS  = 12;
    localparam int START_CYC   = int'(r2_pkg::START_LAST) + 1;
    localparam int SUM_CYC     = int'(r2_pkg::SUM_LAST) + 1;
    localparam int ROW_CYC     = int'(r2_pkg::CUM_LAST) + 2;  // START_ROW plus phase counts.
    localparam int WIN_END     = COLS + 2;     // First cycle with the window closed.
    localparam int MIN_GAP     = COLS + 5;     // Next pulse comes after total_valid.
    localparam int TIMEOUT_CYC = NUM_BURSTS * (COLS + 20) + 200;

    logic               clk;
    logic               rst;
    logic               done_i;
    logic [DATA_W-1:0]  sample_in;
    logic               done_delayed;
    logic               row_valid;
    logic [ROW_W-1:0]   row_sum;
    logic               total_valid;
    logic [TOT_W-1:0]   total_sum;
    logic [7:0]         row_count;

    logic [31:0]        lfsr;
    logic [DATA_W-1:0]  burst_smp [0:WIN_END];  // Sample per cycle after the pulse.
    int                 total_rows   = 0;
    int                 setup_errors = 0;

    r2_top #(.COLS(COLS), .DATA_W(DATA_W)) i_dut (
        .clk          (clk),
        .rst          (rst),
        .done_i       (done_i),
        .sample_in    (sample_in),
        .done_delayed (done_delayed),
        .row_valid    (row_valid),
        .row_sum      (row_sum),
        .total_valid  (total_valid),
        .total_sum    (total_sum),
        .row_count    (row_count)
    );

    r2_checker #(.COLS(COLS), .DATA_W(DATA_W)) i_chk (
        .clk          (clk),
        .rst          (rst),
        .done_i       (done_i),
        .done_delayed (done_delayed),
        .row_valid    (row_valid),
        .row_sum      (row_sum),
        .total_valid  (total_valid),
        .total_sum    (total_sum),
        .row_count    (row_count)
    );

    bind r2_controller r2_props #(.COLS(COLS)) i_props (
        .clk           (clk),
        .rst           (rst),
        .done_i        (done_i),
        .done_delayed  (done_delayed),
        .progress_done (progress_done),
        .state         (state),
        .start_en      (ctl.start_en),
        .ld_en         (ctl.ld_en),
        .sum_en        (ctl.sum_en),
        .cum_en        (ctl.cum_en)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val[i] = lfsr[0];
            lfsr   = lfsr_next(lfsr);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of one burst
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int model_burst();
        logic [ROW_W-1:0] acc;
        logic [TOT_W-1:0] tot;
        int               rows;
        int               t;
        int               pos;
        acc  = '0;
        tot  = '0;
        rows = 0;
        for (t = START_CYC + 1; t <= WIN_END; t++) begin
            pos = (t - START_CYC - 1) % ROW_CYC;
            if (pos == 0) begin
                acc = '0;
            end else if (pos <= SUM_CYC) begin
                acc = acc + ROW_W'(burst_smp[t]);
            end else if (pos == SUM_CYC + 1) begin
                rows++;                    // A row counts once its first CUM_EN cycle runs.
                tot = tot + TOT_W'(acc);
                i_chk.expect_row(acc, tot, 8'(rows));
            end
        end
        i_chk.expect_total(tot, 8'(rows));
        return rows;
    endfunction

    task automatic report_counts(output int total);
        int missing;
        int props;
        missing = i_chk.missing_pulses + i_chk.pending_count();
        props   = i_dut.u_controller.i_props.assert_fails;
        total   = i_chk.value_errors + missing + i_chk.extra_pulses + i_chk.other_errors
                  + props + setup_errors;
        $display("Errors: %0d value, %0d missing, %0d extra, %0d other, %0d assertion",
                 i_chk.value_errors, missing, i_chk.extra_pulses,
                 i_chk.other_errors + setup_errors, props);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        int          gap;
        int          t;
        int          b;
        int          errors;
        rst       = 1'b1;
        done_i    = 1'b0;
        sample_in = '0;
        lfsr      = 32'h5805_b8fc;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        for (b = 0; b < NUM_BURSTS; b++) begin
            burst_smp[0] = '0;
            for (t = 1; t <= WIN_END; t++) begin
                draw_bits(DATA_W, r);
                burst_smp[t] = (t <= COLS + 1) ? r[DATA_W-1:0] : '0;
            end
            total_rows = total_rows + model_burst();
            draw_bits(3, r);
            gap = int'(r[2:0]);
            done_i    <= 1'b1;
            sample_in <= '0;
            @(posedge clk);
            done_i <= 1'b0;
            for (t = 1; t < MIN_GAP + gap; t++) begin
                sample_in <= (t <= WIN_END) ? burst_smp[t] : '0;
                @(posedge clk);
            end
        end
        if (total_rows == 0) begin
            setup_errors++;
            $display("The model produced no complete rows, so nothing was compared");
        end
        while (i_chk.total_seen < NUM_BURSTS) begin
            @(posedge clk);
        end
        repeat (COLS) @(posedge clk);  // Leaves room for a late or extra pulse.
        report_counts(errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        int errors;
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, not every burst delivered total_valid", TIMEOUT_CYC);
        report_counts(errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: r2_stage.f
r2_pkg.sv
r2_ctrl_if.sv
r2_controller.sv
r2_execute.sv
r2_result.sv
r2_top.sv
r2_props.sv
r2_checker.sv
tb_r2.sv

// File: Bender.yml
package:
  name: r2_stage

sources:
  - files:
      - r2_pkg.sv
      - r2_ctrl_if.sv
      - r2_controller.sv
      - r2_execute.sv
      - r2_result.sv
      - r2_top.sv
  - target: test
    files:
      - r2_props.sv
      - r2_checker.sv
      - tb_r2.sv
